/* Makefile */
TOP := aes_encrypt_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* logic/aes_encrypt_ctrl.sv */
`timescale 1ns/1ns

module aes_encrypt_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic load,
    output logic step,
    output logic final_round,
    output logic busy,
    output logic done
);

    localparam logic [3:0] last_round = 4'(aes_pkg::num_rounds);

    logic       busy_q;
    logic [3:0] round_q;  // number of the round applied at the next edge
    logic       done_q;

    assign load        = start && !busy_q;  // a start while busy is dropped
    assign step        = busy_q;
    assign final_round = busy_q && (round_q == last_round);
    assign busy        = busy_q;
    assign done        = done_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            round_q <= 4'd0;
            done_q  <= 1'b0;
        end else begin
            done_q <= final_round;  // one cycle after the last round lands
            if (load) begin
                busy_q  <= 1'b1;
                round_q <= 4'd1;
            end else if (final_round) begin
                busy_q  <= 1'b0;
                round_q <= 4'd0;
            end else if (step) begin
                round_q <= round_q + 4'd1;
            end
        end
    end

    // the next done needs a fresh start, which takes eleven cycles at least
    a_done_single : assert property (
        @(posedge clk) disable iff (!rst_n)
        done_q |=> !done_q
    );

    a_round_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        round_q <= last_round
    );

endmodule

/* logic/aes_encrypt_top.sv */
`timescale 1ns/1ns

module aes_encrypt_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic [aes_pkg::block_bits-1:0] plaintext,
    input  logic [aes_pkg::block_bits-1:0] key,
    output logic [aes_pkg::block_bits-1:0] ciphertext,
    output logic                           busy,
    output logic                           done
);

    logic                           load;
    logic                           step;
    logic                           final_round;
    logic [aes_pkg::block_bits-1:0] round_key;

    aes_encrypt_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .load        (load),
        .step        (step),
        .final_round (final_round),
        .busy        (busy),
        .done        (done)
    );

    // steps alongside the datapath, one round key per edge
    aes_key_schedule u_key_schedule (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .step      (step),
        .key       (key),
        .round_key (round_key)
    );

    aes_round_datapath u_datapath (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (load),
        .step        (step),
        .final_round (final_round),
        .plaintext   (plaintext),
        .key         (key),
        .round_key   (round_key),
        .ciphertext  (ciphertext)
    );

endmodule

/* logic/aes_key_schedule.sv */
`timescale 1ns/1ns

module aes_key_schedule (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           load,
    input  logic                           step,
    input  logic [aes_pkg::block_bits-1:0] key,
    output logic [aes_pkg::block_bits-1:0] round_key
);

    logic [aes_pkg::block_bits-1:0] key_q;
    aes_pkg::byte_t                 rcon_q;

    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    logic [31:0] rot_w3;
    logic [31:0] sub_w3;
    logic [31:0] temp;
    logic [31:0] n0;
    logic [31:0] n1;
    logic [31:0] n2;
    logic [31:0] n3;

    assign {w0, w1, w2, w3} = key_q;

    assign rot_w3 = {w3[23:0], w3[31:24]};  // RotWord moves the top byte to the bottom

    genvar k;
    generate
        for (k = 0; k < 4; k++) begin : g_subword
            assign sub_w3[8*k +: 8] = aes_pkg::sbox(rot_w3[8*k +: 8]);
        end
    endgenerate

    assign temp = sub_w3 ^ {rcon_q, 24'h000000};

    // each new word leans on the one before it
    assign n0 = w0 ^ temp;
    assign n1 = w1 ^ n0;
    assign n2 = w2 ^ n1;
    assign n3 = w3 ^ n2;

    assign round_key = {n0, n1, n2, n3};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rcon_q <= '0;
        end else if (load) begin
            rcon_q <= aes_pkg::rcon_init;
        end else if (step) begin
            rcon_q <= aes_pkg::xtime(rcon_q);  // 01, 02, 04 ... 80, 1b, 36
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            key_q <= key;
        end else if (step) begin
            key_q <= round_key;
        end
    end

    // a step without a prior load would expand with a zero round constant
    a_rcon_loaded : assert property (
        @(posedge clk) disable iff (!rst_n)
        step |-> (rcon_q != 8'h00)
    );

endmodule

/* logic/aes_pkg.sv */
package aes_pkg;

    localparam int block_bits = 128;         // state, key, plaintext and ciphertext width
    localparam int num_rounds = 10;          // AES-128 round count

    typedef logic [7:0] byte_t;

    localparam byte_t rcon_init = 8'h01;     // round constant for the first expansion step

    // forward S-box, sixteen rows of sixteen entries, entry 0 in the top byte
    localparam logic [0:255][7:0] sbox_table = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic byte_t sbox(input byte_t b);
        return sbox_table[b];
    endfunction

    // multiply by x in GF(2^8), reducing with the AES polynomial
    function automatic byte_t xtime(input byte_t b);
        byte_t shifted;
        shifted = {b[6:0], 1'b0};
        if (b[7]) begin
            shifted = shifted ^ 8'h1b;
        end
        return shifted;
    endfunction

endpackage

/* logic/aes_round_datapath.sv */
`timescale 1ns/1ns

module aes_round_datapath (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           load,
    input  logic                           step,
    input  logic                           final_round,
    input  logic [aes_pkg::block_bits-1:0] plaintext,
    input  logic [aes_pkg::block_bits-1:0] key,
    input  logic [aes_pkg::block_bits-1:0] round_key,
    output logic [aes_pkg::block_bits-1:0] ciphertext
);

    logic [aes_pkg::block_bits-1:0] state_q;

    // byte views, index 0 is the most significant byte as in FIPS-197
    aes_pkg::byte_t [0:15] state_b;
    aes_pkg::byte_t [0:15] sub_b;
    aes_pkg::byte_t [0:15] shift_b;
    aes_pkg::byte_t [0:15] mix_b;
    aes_pkg::byte_t [0:15] rk_b;
    aes_pkg::byte_t [0:15] next_b;

    assign state_b = state_q;
    assign rk_b    = round_key;

    genvar i;
    generate
        for (i = 0; i < 16; i++) begin : g_byte
            localparam int row   = i % 4;
            localparam int col   = i / 4;
            localparam int src   = 4 * ((col + row) % 4) + row;  // ShiftRows source byte
            localparam int base  = 4 * col;
            localparam int r1    = base + (row + 1) % 4;
            localparam int r2    = base + (row + 2) % 4;
            localparam int r3    = base + (row + 3) % 4;

            assign sub_b[i]   = aes_pkg::sbox(state_b[i]);
            assign shift_b[i] = sub_b[src];

            // 2*a0 ^ 3*a1 ^ a2 ^ a3 with the row rotated into place
            assign mix_b[i] = final_round ? shift_b[i] :
                              aes_pkg::xtime(shift_b[base + row]) ^
                              aes_pkg::xtime(shift_b[r1]) ^ shift_b[r1] ^
                              shift_b[r2] ^ shift_b[r3];

            assign next_b[i] = mix_b[i] ^ rk_b[i];  // AddRoundKey closes the round
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= '0;
        end else if (load) begin
            state_q <= plaintext ^ key;  // initial whitening with the cipher key
        end else if (step) begin
            state_q <= next_b;
        end
    end

    assign ciphertext = state_q;  // holds the final state until the next load

    // the control must never start a block on top of a running round
    a_load_step_exclusive : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load && step)
    );

endmodule

/* verif/aes_encrypt_tb.sv */
`timescale 1ns/1ns

module aes_encrypt_tb;

    localparam int max_cycles  = 200;  // six encryptions of eleven cycles, reset and slack
    localparam int done_window = aes_pkg::num_rounds + 5;

    // known-answer vectors from FIPS-197 appendix C.1 and appendix B
    localparam logic [127:0] c1_key   = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] c1_plain = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] c1_ct    = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam logic [127:0] b_key    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam logic [127:0] b_plain  = 128'h3243f6a8885a308d313198a2e0370734;
    localparam logic [127:0] b_ct     = 128'h3925841d02dc09fbdc118597196a0b32;
    localparam logic [127:0] zero_ct  = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

    logic         clk;
    logic         rst_n;
    logic         start;
    logic [127:0] plaintext;
    logic [127:0] key;
    logic [127:0] ciphertext;
    logic         busy;
    logic         done;
    int           cycle_count = 0;

    aes_encrypt_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .plaintext  (plaintext),
        .key        (key),
        .ciphertext (ciphertext),
        .busy       (busy),
        .done       (done)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("run exceeded %0d cycles without finishing", max_cycles);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    // one clock, landing just after the edge where outputs are settled
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic [127:0] expected, input logic [127:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_flag(input string test_name, input string what,
                              input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("FAILED %s: %s expected %b actual %b", test_name, what, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_count(input string test_name, input string what,
                               input int expected, input int actual);
        assert (actual == expected) else begin
            $display("FAILED %s: %s expected %0d actual %0d", test_name, what, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic report_problem(input string test_name, input string msg);
        $display("%s: %s", test_name, msg);
        $display("=== FAIL ===");
        $fatal(1, "check failed");
    endtask

    // raises start for one edge, returns just after the edge that samples it
    task automatic apply_start(input logic [127:0] pt, input logic [127:0] k);
        start     = 1'b1;
        plaintext = pt;
        key       = k;
        tick();
        start     = 1'b0;
    endtask

    // elapsed counts the edges already past the one that sampled start
    task automatic wait_done(input string test_name, input logic [127:0] expected,
                             input int elapsed);
        int cycles;
        cycles = elapsed;
        while (done !== 1'b1) begin
            check_flag(test_name, "busy while running", 1'b1, busy);
            if (cycles >= done_window) begin
                report_problem(test_name, "done never came after start was accepted");
            end
            tick();
            cycles++;
        end
        check_count(test_name, "cycles from start to done", aes_pkg::num_rounds, cycles);
        check_value(test_name, "ciphertext at done", expected, ciphertext);
        check_flag(test_name, "busy at done", 1'b0, busy);
    endtask

    task automatic check_idle_hold(input string test_name, input logic [127:0] expected);
        repeat (2) begin
            tick();
            check_flag(test_name, "done after its single cycle", 1'b0, done);
            check_flag(test_name, "busy while idle", 1'b0, busy);
            check_value(test_name, "ciphertext while idle", expected, ciphertext);
        end
    endtask

    task automatic test_reset_state();
        repeat (2) begin
            check_flag("reset", "busy", 1'b0, busy);
            check_flag("reset", "done", 1'b0, done);
            check_value("reset", "ciphertext", '0, ciphertext);
            tick();
        end
    endtask

    task automatic test_known_answer(input string test_name, input logic [127:0] pt,
                                     input logic [127:0] k, input logic [127:0] expected);
        apply_start(pt, k);
        check_flag(test_name, "done right after start", 1'b0, done);
        wait_done(test_name, expected, 0);
        check_idle_hold(test_name, expected);
    endtask

    task automatic test_start_while_busy();
        apply_start(c1_plain, c1_key);
        repeat (4) begin
            check_flag("start_while_busy", "busy before second start", 1'b1, busy);
            tick();
        end
        start     = 1'b1;  // lands on the fifth round edge and must be dropped
        plaintext = b_plain;
        key       = b_key;
        tick();
        start     = 1'b0;
        wait_done("start_while_busy", c1_ct, 5);
        check_idle_hold("start_while_busy", c1_ct);
    endtask

    task automatic test_back_to_back();
        apply_start(c1_plain, c1_key);
        wait_done("back_to_back_first", c1_ct, 0);
        // ciphertext is the state register, so it follows the second block from its load
        apply_start(b_plain, b_key);
        check_flag("back_to_back", "done after its single cycle", 1'b0, done);
        check_flag("back_to_back", "busy after second start", 1'b1, busy);
        wait_done("back_to_back_second", b_ct, 0);
        check_idle_hold("back_to_back_second", b_ct);
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        plaintext = '0;
        key       = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_known_answer("fips_c1", c1_plain, c1_key, c1_ct);
        test_known_answer("fips_b", b_plain, b_key, b_ct);
        test_known_answer("all_zero", '0, '0, zero_ct);
        test_start_while_busy();
        test_back_to_back();

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* verilog.f */
logic/aes_pkg.sv
logic/aes_round_datapath.sv
logic/aes_key_schedule.sv
logic/aes_encrypt_ctrl.sv
logic/aes_encrypt_top.sv
verif/aes_encrypt_tb.sv
